// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := lsu_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/lsu_properties.sv ====
`timescale 1ns/1ps

module lsu_properties (
  input logic                     clk_i,
  input logic                     rst_ni,
  input lsu_pipe_pkg::ld_result_t load_result_i,
  input lsu_pipe_pkg::st_result_t store_result_i
);

  // Quiet in reset and for 3 cycles after its release
  a_quiet_after_reset: assert property (@(posedge clk_i)
    (!rst_ni || !$past(rst_ni) || !$past(rst_ni, 2) || !$past(rst_ni, 3))
      |-> (!load_result_i.valid && !store_result_i.valid))
    else $error("result valid during or right after reset");

  // ----------------------------
  // Exceptions
  // ----------------------------
  a_ld_ex_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_result_i.ex.valid |-> load_result_i.valid)
    else $error("load exception without a valid load result");

  a_st_ex_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_result_i.ex.valid |-> store_result_i.valid)
    else $error("store exception without a valid store result");

  a_ld_cause_kind: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_result_i.ex.valid |->
      (load_result_i.ex.cause == lsu_isa_pkg::LD_ADDR_MISALIGNED ||
       load_result_i.ex.cause == lsu_isa_pkg::LD_ACCESS_FAULT))
    else $error("load result carries a non-load cause");

  a_st_cause_kind: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_result_i.ex.valid |->
      (store_result_i.ex.cause == lsu_isa_pkg::ST_ADDR_MISALIGNED ||
       store_result_i.ex.cause == lsu_isa_pkg::ST_ACCESS_FAULT))
    else $error("store result carries a non-store cause");

endmodule

bind load_store_unit lsu_properties i_properties (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .load_result_i  (load_result_o),
  .store_result_i (store_result_o)
);

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb;

  localparam int ResetCycles = 10;
  localparam int IdleCycles  = 5;
  localparam int StimCycles  = 580;
  localparam int DrainCycles = 10;
  localparam int BurstStart  = IdleCycles + 300;
  localparam int BurstLen    = 40;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     lsu_valid_i;
  lsu_pipe_pkg::lsu_req_t   lsu_req_i;
  lsu_pipe_pkg::ld_result_t load_result_o;
  lsu_pipe_pkg::st_result_t store_result_o;

  integer     seed;
  int         cyc;
  int         n_ops;
  int         ld_errors;
  int         st_errors;
  logic [7:0] model_mem [`LSU_RAM_BYTES];

  // Operation and address of the most recent request
  lsu_isa_pkg::mem_op_e last_op;
  logic [31:0]          last_vaddr;

  // Expected results with the cycle on which each one is due
  lsu_pipe_pkg::ld_result_t ld_exp_q[$];
  int                       ld_due_q[$];
  lsu_pipe_pkg::st_result_t st_exp_q[$];
  int                       st_due_q[$];

  load_store_unit load_store_unit_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_valid_i    (lsu_valid_i),
    .lsu_req_i      (lsu_req_i),
    .load_result_o  (load_result_o),
    .store_result_o (store_result_o)
  );

  always #10 clk_i = ~clk_i;

  // ----------------------------
  // Compare tasks
  // ----------------------------
  task automatic check_load(input lsu_pipe_pkg::ld_result_t exp_r,
                            input lsu_pipe_pkg::ld_result_t act_r);
    if (act_r !== exp_r) begin
      ld_errors++;
      $display("[FAIL] t=%0t load_result_o expected %h actual %h", $time, exp_r, act_r);
    end
  endtask

  task automatic check_store(input lsu_pipe_pkg::st_result_t exp_r,
                             input lsu_pipe_pkg::st_result_t act_r);
    if (act_r !== exp_r) begin
      st_errors++;
      $display("[FAIL] t=%0t store_result_o expected %h actual %h", $time, exp_r, act_r);
    end
  endtask

  // ----------------------------
  // Stimulus and reference model
  // ----------------------------
  // kind 0 is fully random, 1 an in-range store, 2 a load from the previous address
  task automatic send_op(input int kind);
    lsu_pipe_pkg::lsu_req_t          req;
    lsu_pipe_pkg::ld_result_t        ld_r;
    lsu_pipe_pkg::st_result_t        st_r;
    lsu_isa_pkg::exception_t         ex;
    logic [3:0]                      op_bits;
    logic [31:0]                     vaddr;
    logic [31:0]                     word;
    logic [`LSU_RAM_ADDR_BITS-1:0]   idx;
    int                              size;
    int                              mode;
    bit                              is_load;
    op_bits = 4'({$random(seed)} % 8);
    if (kind == 1) op_bits = 4'(lsu_isa_pkg::SB + {$random(seed)} % 3);
    if (kind == 2) begin
      // Same width as the store before it, either signedness
      case (last_op)
        lsu_isa_pkg::SB: op_bits = ({$random(seed)} % 2) ? lsu_isa_pkg::LBU : lsu_isa_pkg::LB;
        lsu_isa_pkg::SH: op_bits = ({$random(seed)} % 2) ? lsu_isa_pkg::LHU : lsu_isa_pkg::LH;
        default:         op_bits = lsu_isa_pkg::LW;
      endcase
    end
    req.operation = lsu_isa_pkg::mem_op_e'(op_bits);
    is_load       = (req.operation <= lsu_isa_pkg::LW);
    case (req.operation)
      lsu_isa_pkg::LB, lsu_isa_pkg::LBU, lsu_isa_pkg::SB: size = 1;
      lsu_isa_pkg::LH, lsu_isa_pkg::LHU, lsu_isa_pkg::SH: size = 2;
      default: size = 4;
    endcase
    // Mostly aligned and in range, the rest misaligned or far out
    mode = {$random(seed)} % 16;
    if (kind == 2) vaddr = last_vaddr;
    else if (kind == 1 || mode < 11) vaddr = ({$random(seed)} % `LSU_RAM_BYTES) & ~(size - 1);
    else if (mode < 14) vaddr = {$random(seed)} % `LSU_RAM_BYTES;
    else if (mode < 15) vaddr = 32'd256 + ({$random(seed)} % 4096);
    else vaddr = $random(seed);
    req.imm       = $random(seed) % 32;
    req.operand_a = vaddr - req.imm;
    req.operand_b = $random(seed);
    req.trans_id  = `LSU_TRANS_ID_BITS'(n_ops);
    n_ops++;
    last_op    = req.operation;
    last_vaddr = vaddr;
    ex = '0;
    if ((vaddr % size) != 0) begin
      ex.valid = 1'b1;
      ex.cause = is_load ? lsu_isa_pkg::LD_ADDR_MISALIGNED : lsu_isa_pkg::ST_ADDR_MISALIGNED;
    end else if (vaddr >= `LSU_RAM_BYTES) begin
      ex.valid = 1'b1;
      ex.cause = is_load ? lsu_isa_pkg::LD_ACCESS_FAULT : lsu_isa_pkg::ST_ACCESS_FAULT;
    end
    if (ex.valid) ex.tval = vaddr;
    word = '0;
    if (!ex.valid) begin
      for (int i = 0; i < size; i++) begin
        idx = vaddr[`LSU_RAM_ADDR_BITS-1:0] + `LSU_RAM_ADDR_BITS'(i);
        if (is_load) word[8*i +: 8] = model_mem[idx];
        else model_mem[idx] = req.operand_b[8*i +: 8];
      end
      if (req.operation == lsu_isa_pkg::LB) word = {{24{word[7]}}, word[7:0]};
      if (req.operation == lsu_isa_pkg::LH) word = {{16{word[15]}}, word[15:0]};
    end
    if (is_load) begin
      ld_r = '{valid: 1'b1, trans_id: req.trans_id, data: word, ex: ex};
      ld_exp_q.push_back(ld_r);
      ld_due_q.push_back(cyc + 3 + `LSU_LOAD_PIPE_REGS);
    end else begin
      st_r = '{valid: 1'b1, trans_id: req.trans_id, ex: ex};
      st_exp_q.push_back(st_r);
      st_due_q.push_back(cyc + 3 + `LSU_STORE_PIPE_REGS);
    end
    lsu_valid_i <= 1'b1;
    lsu_req_i   <= req;
  endtask

  // Results are due on one exact cycle, anything else is an error
  task automatic check_outputs();
    lsu_pipe_pkg::ld_result_t ld_e;
    lsu_pipe_pkg::st_result_t st_e;
    if (ld_due_q.size() > 0 && ld_due_q[0] == cyc) begin
      ld_e = ld_exp_q.pop_front();
      void'(ld_due_q.pop_front());
      if (!load_result_o.valid) begin
        ld_errors++;
        $display("Load result for trans_id %0d did not arrive at %0t", ld_e.trans_id, $time);
      end else begin
        check_load(ld_e, load_result_o);
      end
    end else if (load_result_o.valid) begin
      ld_errors++;
      $display("Unexpected load result, trans_id %0d at %0t", load_result_o.trans_id, $time);
    end
    if (st_due_q.size() > 0 && st_due_q[0] == cyc) begin
      st_e = st_exp_q.pop_front();
      void'(st_due_q.pop_front());
      if (!store_result_o.valid) begin
        st_errors++;
        $display("Store result for trans_id %0d did not arrive at %0t", st_e.trans_id, $time);
      end else begin
        check_store(st_e, store_result_o);
      end
    end else if (store_result_o.valid) begin
      st_errors++;
      $display("Unexpected store result, trans_id %0d at %0t", store_result_o.trans_id, $time);
    end
  endtask

  // ----------------------------
  // Main sequence
  // ----------------------------
  initial begin
    bit in_stim;
    bit in_burst;
    seed        = 4;
    cyc         = 0;
    n_ops       = 0;
    ld_errors   = 0;
    st_errors   = 0;
    last_op     = lsu_isa_pkg::LB;
    last_vaddr  = '0;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    lsu_valid_i = 1'b0;
    lsu_req_i   = '0;
    for (int i = 0; i < `LSU_RAM_BYTES; i++) begin
      model_mem[i] = '0;
    end
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int c = 0; c < IdleCycles + StimCycles + DrainCycles; c++) begin
      @(posedge clk_i);
      cyc++;
      in_stim  = (c >= IdleCycles) && (c < IdleCycles + StimCycles);
      in_burst = (c >= BurstStart) && (c < BurstStart + BurstLen);
      // Valid on about 70% of cycles, always inside the burst
      // In the burst each store is followed at once by a load of the same address
      if (in_stim && (in_burst || ({$random(seed)} % 10 < 7))) begin
        if (!in_burst) send_op(0);
        else if ((c - BurstStart) % 2 == 0) send_op(1);
        else send_op(2);
      end else begin
        lsu_valid_i <= 1'b0;
      end
      @(negedge clk_i);
      check_outputs();
    end
    if (ld_exp_q.size() > 0 || st_exp_q.size() > 0) begin
      ld_errors += ld_exp_q.size();
      st_errors += st_exp_q.size();
      $display("Results still outstanding at the end of the run");
    end
    $display("Operations %0d, load errors %0d, store errors %0d", n_ops, ld_errors, st_errors);
    if (ld_errors == 0 && st_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((ResetCycles + IdleCycles + StimCycles + DrainCycles + 20) * 20);
    $display("Timeout, the run did not finish in time");
    $display("sim failed");
    $finish;
  end

endmodule

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module load_store_unit (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     lsu_valid_i,
  input  lsu_pipe_pkg::lsu_req_t   lsu_req_i,
  output lsu_pipe_pkg::ld_result_t load_result_o,
  output lsu_pipe_pkg::st_result_t store_result_o
);

  lsu_pipe_pkg::lsu_ctrl_t  lsu_ctrl;
  lsu_pipe_pkg::ld_result_t ld_result;
  lsu_pipe_pkg::st_result_t st_result;

  // ----------------------------
  // Issue and memory stages
  // ----------------------------
  lsu_issue i_issue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lsu_valid_i (lsu_valid_i),
    .lsu_req_i   (lsu_req_i),
    .ctrl_o      (lsu_ctrl)
  );

  lsu_mem_stage i_mem_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ctrl_i      (lsu_ctrl),
    .ld_result_o (ld_result),
    .st_result_o (st_result)
  );

  // ----------------------------
  // Output pipeline registers
  // ----------------------------
  lsu_result_pipe #(
    .DEPTH (`LSU_LOAD_PIPE_REGS),
    .WIDTH ($bits(lsu_pipe_pkg::ld_result_t))
  ) i_load_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (ld_result),
    .d_o    (load_result_o)
  );

  lsu_result_pipe #(
    .DEPTH (`LSU_STORE_PIPE_REGS),
    .WIDTH ($bits(lsu_pipe_pkg::st_result_t))
  ) i_store_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (st_result),
    .d_o    (store_result_o)
  );

endmodule

// ==== logic/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// ----------------------------
// Datapath widths
// ----------------------------

// Data and address width
`define LSU_XLEN 32

// Transaction ID carried from issue to writeback
`define LSU_TRANS_ID_BITS 3

// ----------------------------
// Scratchpad
// ----------------------------

// Size in bytes, addressable range is 0 to LSU_RAM_BYTES-1
`define LSU_RAM_BYTES 256
`define LSU_RAM_ADDR_BITS 8

// ----------------------------
// Result pipelines
// ----------------------------

`define LSU_LOAD_PIPE_REGS 1
`define LSU_STORE_PIPE_REGS 2

`endif

// ==== logic/lsu_isa_pkg.sv ====
`include "lsu_defs.svh"

package lsu_isa_pkg;

  // ----------------------------
  // Memory operations
  // ----------------------------
  typedef enum logic [3:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } mem_op_e;

  // Functional unit that executes the operation
  typedef enum logic [1:0] {
    FU_NONE,
    FU_LOAD,
    FU_STORE
  } fu_e;

  // ----------------------------
  // Exceptions
  // ----------------------------

  // Architectural mcause codes for the memory faults raised here
  typedef enum logic [3:0] {
    LD_ADDR_MISALIGNED = 4'd4,
    LD_ACCESS_FAULT    = 4'd5,
    ST_ADDR_MISALIGNED = 4'd6,
    ST_ACCESS_FAULT    = 4'd7
  } exc_cause_e;

  // tval holds the faulting address
  typedef struct packed {
    logic                 valid;
    exc_cause_e           cause;
    logic [`LSU_XLEN-1:0] tval;
  } exception_t;

endpackage

// ==== logic/lsu_issue.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_issue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    lsu_valid_i,
  input  lsu_pipe_pkg::lsu_req_t  lsu_req_i,
  output lsu_pipe_pkg::lsu_ctrl_t ctrl_o
);

  logic [`LSU_XLEN-1:0]    vaddr;
  lsu_isa_pkg::fu_e        fu;
  logic [1:0]              size;
  logic [3:0]              be;
  logic                    misaligned;
  logic                    out_of_range;
  lsu_isa_pkg::exception_t ex;

  // ----------------------------
  // Address generation
  // ----------------------------
  // imm arrives already sign-extended to XLEN
  assign vaddr = $unsigned($signed(lsu_req_i.operand_a) + $signed(lsu_req_i.imm));

  // Unit and transfer size from the opcode, size 0 byte, 1 half, 2 word
  always_comb begin
    fu   = lsu_isa_pkg::FU_NONE;
    size = 2'd0;
    case (lsu_req_i.operation)
      lsu_isa_pkg::LB, lsu_isa_pkg::LBU: begin
        fu   = lsu_isa_pkg::FU_LOAD;
        size = 2'd0;
      end
      lsu_isa_pkg::LH, lsu_isa_pkg::LHU: begin
        fu   = lsu_isa_pkg::FU_LOAD;
        size = 2'd1;
      end
      lsu_isa_pkg::LW: begin
        fu   = lsu_isa_pkg::FU_LOAD;
        size = 2'd2;
      end
      lsu_isa_pkg::SB: begin
        fu   = lsu_isa_pkg::FU_STORE;
        size = 2'd0;
      end
      lsu_isa_pkg::SH: begin
        fu   = lsu_isa_pkg::FU_STORE;
        size = 2'd1;
      end
      lsu_isa_pkg::SW: begin
        fu   = lsu_isa_pkg::FU_STORE;
        size = 2'd2;
      end
      default: ;
    endcase
  end

  // Byte enables within the 32-bit word
  always_comb begin
    case (size)
      2'd0:    be = 4'b0001 << vaddr[1:0];
      2'd1:    be = 4'b0011 << vaddr[1:0];
      default: be = 4'b1111;
    endcase
  end

  // ----------------------------
  // Fault checks
  // ----------------------------
  assign misaligned   = ((size == 2'd1) && vaddr[0]) || ((size == 2'd2) && (vaddr[1:0] != 2'b00));
  assign out_of_range = |vaddr[`LSU_XLEN-1:`LSU_RAM_ADDR_BITS];

  // Misalignment takes priority over the range check
  always_comb begin
    ex = '0;
    if (lsu_valid_i && (fu != lsu_isa_pkg::FU_NONE) && (misaligned || out_of_range)) begin
      ex.valid = 1'b1;
      ex.tval  = vaddr;
      if (fu == lsu_isa_pkg::FU_LOAD) begin
        ex.cause = misaligned ? lsu_isa_pkg::LD_ADDR_MISALIGNED : lsu_isa_pkg::LD_ACCESS_FAULT;
      end else begin
        ex.cause = misaligned ? lsu_isa_pkg::ST_ADDR_MISALIGNED : lsu_isa_pkg::ST_ACCESS_FAULT;
      end
    end
  end

  // Request register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_o <= '0;
    end else begin
      ctrl_o.valid     <= lsu_valid_i;
      ctrl_o.fu        <= fu;
      ctrl_o.operation <= lsu_req_i.operation;
      ctrl_o.vaddr     <= vaddr;
      ctrl_o.wdata     <= lsu_req_i.operand_b;
      ctrl_o.be        <= be;
      ctrl_o.trans_id  <= lsu_req_i.trans_id;
      ctrl_o.ex        <= ex;
    end
  end

endmodule

// ==== logic/lsu_mem_stage.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_mem_stage (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  lsu_pipe_pkg::lsu_ctrl_t  ctrl_i,
  output lsu_pipe_pkg::ld_result_t ld_result_o,
  output lsu_pipe_pkg::st_result_t st_result_o
);

  localparam int unsigned Words   = `LSU_RAM_BYTES / 4;
  localparam int unsigned IdxBits = $clog2(Words);

  lsu_pipe_pkg::lsu_ctrl_t  ctrl_q;
  logic [`LSU_XLEN-1:0]     ram [Words];
  logic [IdxBits-1:0]       word_idx;
  logic [1:0]               byte_off;
  logic                     do_load;
  logic                     do_store;
  logic [`LSU_XLEN-1:0]     rdata_shifted;
  logic [`LSU_XLEN-1:0]     wdata_shifted;
  logic [`LSU_XLEN-1:0]     ld_data;
  lsu_pipe_pkg::ld_result_t ld_d;
  lsu_pipe_pkg::st_result_t st_d;

  // Address register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_i;
    end
  end

  assign word_idx = ctrl_q.vaddr[`LSU_RAM_ADDR_BITS-1:2];
  assign byte_off = ctrl_q.vaddr[1:0];

  // Faulting operations never reach the RAM
  assign do_load  = ctrl_q.valid && (ctrl_q.fu == lsu_isa_pkg::FU_LOAD) && !ctrl_q.ex.valid;
  assign do_store = ctrl_q.valid && (ctrl_q.fu == lsu_isa_pkg::FU_STORE) && !ctrl_q.ex.valid;

  // ----------------------------
  // Scratchpad
  // ----------------------------
  assign wdata_shifted = ctrl_q.wdata << {byte_off, 3'b000};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Words; i++) begin
        ram[i] <= '0;
      end
    end else if (do_store) begin
      for (int b = 0; b < 4; b++) begin
        if (ctrl_q.be[b]) begin
          ram[word_idx][8*b +: 8] <= wdata_shifted[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------
  // Load formatting
  // ----------------------------
  assign rdata_shifted = ram[word_idx] >> {byte_off, 3'b000};

  always_comb begin
    case (ctrl_q.operation)
      lsu_isa_pkg::LB:  ld_data = {{(`LSU_XLEN-8){rdata_shifted[7]}}, rdata_shifted[7:0]};
      lsu_isa_pkg::LBU: ld_data = {{(`LSU_XLEN-8){1'b0}}, rdata_shifted[7:0]};
      lsu_isa_pkg::LH:  ld_data = {{(`LSU_XLEN-16){rdata_shifted[15]}}, rdata_shifted[15:0]};
      lsu_isa_pkg::LHU: ld_data = {{(`LSU_XLEN-16){1'b0}}, rdata_shifted[15:0]};
      default:          ld_data = rdata_shifted;
    endcase
  end

  // Steer to the load or store path by unit
  always_comb begin
    ld_d = '0;
    st_d = '0;
    if (ctrl_q.valid && (ctrl_q.fu == lsu_isa_pkg::FU_LOAD)) begin
      ld_d.valid    = 1'b1;
      ld_d.trans_id = ctrl_q.trans_id;
      ld_d.data     = do_load ? ld_data : '0;
      ld_d.ex       = ctrl_q.ex;
    end
    if (ctrl_q.valid && (ctrl_q.fu == lsu_isa_pkg::FU_STORE)) begin
      st_d.valid    = 1'b1;
      st_d.trans_id = ctrl_q.trans_id;
      st_d.ex       = ctrl_q.ex;
    end
  end

  // Result registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_result_o <= '0;
      st_result_o <= '0;
    end else begin
      ld_result_o <= ld_d;
      st_result_o <= st_d;
    end
  end

endmodule

// ==== logic/lsu_pipe_pkg.sv ====
`include "lsu_defs.svh"

package lsu_pipe_pkg;

  // ----------------------------
  // Issue side
  // ----------------------------

  // Request from the issue stage, operand_b is the store data
  typedef struct packed {
    lsu_isa_pkg::mem_op_e          operation;
    logic [`LSU_XLEN-1:0]          operand_a;
    logic [`LSU_XLEN-1:0]          operand_b;
    logic [`LSU_XLEN-1:0]          imm;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
  } lsu_req_t;

  // Checked request passed between the stages
  typedef struct packed {
    logic                          valid;
    lsu_isa_pkg::fu_e              fu;
    lsu_isa_pkg::mem_op_e          operation;
    logic [`LSU_XLEN-1:0]          vaddr;
    logic [`LSU_XLEN-1:0]          wdata;
    logic [3:0]                    be;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    lsu_isa_pkg::exception_t       ex;
  } lsu_ctrl_t;

  // ----------------------------
  // Result side
  // ----------------------------
  typedef struct packed {
    logic                          valid;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    logic [`LSU_XLEN-1:0]          data;
    lsu_isa_pkg::exception_t       ex;
  } ld_result_t;

  // Stores return no data, only completion and a possible fault
  typedef struct packed {
    logic                          valid;
    logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    lsu_isa_pkg::exception_t       ex;
  } st_result_t;

endpackage

// ==== logic/lsu_result_pipe.sv ====
`timescale 1ns/1ps

module lsu_result_pipe #(
  parameter int unsigned DEPTH = 1,
  parameter int unsigned WIDTH = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [WIDTH-1:0] d_i,
  output logic [WIDTH-1:0] d_o
);

  if (DEPTH == 0) begin : gen_bypass
    assign d_o = d_i;
  end else begin : gen_stages
    logic [WIDTH-1:0] stage_q [DEPTH];

    // Stage 0 takes the input, the last stage drives the output
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int i = 0; i < DEPTH; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= d_i;
        for (int i = 1; i < DEPTH; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign d_o = stage_q[DEPTH-1];
  end

endmodule

// ==== sim.f ====
+incdir+logic
logic/lsu_isa_pkg.sv
logic/lsu_pipe_pkg.sv
logic/lsu_result_pipe.sv
logic/lsu_issue.sv
logic/lsu_mem_stage.sv
logic/load_store_unit.sv
bench/lsu_properties.sv
bench/lsu_tb.sv
